//--- common/vpu_pkg.sv
package vpu_pkg;

   localparam int VRF_DEPTH       = 256;
   localparam int VL_RESET        = 4;
   localparam int VL_MAX          = 16;
   localparam int NUM_PORT_GROUPS = 4;

   typedef logic [15:0] elem_t;
   typedef logic [7:0]  vaddr_t;

   // Holds 1 to 16, so one bit wider than a 0..15 count
   typedef logic [4:0]  vlen_t;

   typedef enum logic [2:0] {
      OP_ADD   = 3'd0,
      OP_SUB   = 3'd1,
      OP_AND   = 3'd2,
      OP_XOR   = 3'd3,
      OP_SETVL = 3'd4
   } opcode_t;

   // imm only matters for OP_SETVL
   typedef struct packed {
      opcode_t opcode;
      vaddr_t  vd;
      vaddr_t  vs1;
      vaddr_t  vs2;
      vlen_t   imm;
   } vec_instr_t;

   typedef struct packed {
      opcode_t opcode;
      vaddr_t  vd;
      vaddr_t  vs1;
      vaddr_t  vs2;
      vlen_t   vl;
   } port_cmd_t;

   typedef struct packed {
      logic   cyc;
      logic   stb;
      logic   we;
      vaddr_t adr;
      elem_t  dat;
   } wb_req_t;

   typedef struct packed {
      logic  ack;
      elem_t dat;
   } wb_rsp_t;

   typedef enum logic [1:0] {
      PG_IDLE = 2'd0,
      PG_RD1  = 2'd1,
      PG_RD2  = 2'd2,
      PG_WR   = 2'd3
   } pg_state_t;

endpackage

//--- verilog/port_allocate_unit.sv
`timescale 1ns/100ps

module port_allocate_unit #(
   parameter int W_PORTS_NUM = vpu_pkg::NUM_PORT_GROUPS
) (
   input  logic                   clk,
   input  logic                   rstn,

   input  logic                   instr_vld_i,
   input  vpu_pkg::vec_instr_t    instr_i,
   output logic                   instr_rdy_o,

   input  logic [W_PORTS_NUM-1:0] port_rdy_i,
   output logic [W_PORTS_NUM-1:0] start_o,
   output vpu_pkg::port_cmd_t     cmd_o,
   output logic                   idle_o
);

   localparam int PTR_W = (W_PORTS_NUM > 1) ? $clog2(W_PORTS_NUM) : 1;

   logic [PTR_W-1:0] ptr_q;
   logic [PTR_W-1:0] ptr_next;
   vpu_pkg::vlen_t   vl_q;
   logic             is_setvl;
   logic             all_idle;
   logic             accept;
   logic             alloc;

   // Zero length would never end a group, and lengths past 16 run off the register
   function automatic vpu_pkg::vlen_t clamp_vl(input vpu_pkg::vlen_t imm);
      vpu_pkg::vlen_t res;
      if (imm == '0)
      begin
         res = vpu_pkg::vlen_t'(1);
      end
      else if (imm > vpu_pkg::vlen_t'(vpu_pkg::VL_MAX))
      begin
         res = vpu_pkg::vlen_t'(vpu_pkg::VL_MAX);
      end
      else
      begin
         res = imm;
      end
      return res;
   endfunction

   assign is_setvl = (instr_i.opcode == vpu_pkg::OP_SETVL);
   assign all_idle = &port_rdy_i;

   // Config waits for every group, arithmetic only for the group at the pointer
   assign instr_rdy_o = is_setvl ? all_idle : port_rdy_i[ptr_q];

   assign accept = instr_vld_i && instr_rdy_o;
   assign alloc  = accept && !is_setvl;

   always_comb
   begin
      for (int i = 0; i < W_PORTS_NUM; i++)
      begin
         start_o[i] = alloc && (ptr_q == PTR_W'(i));
      end
   end

   always_comb
   begin
      cmd_o.opcode = instr_i.opcode;
      cmd_o.vd     = instr_i.vd;
      cmd_o.vs1    = instr_i.vs1;
      cmd_o.vs2    = instr_i.vs2;
      cmd_o.vl     = vl_q;
   end

   assign ptr_next = (ptr_q == PTR_W'(W_PORTS_NUM - 1)) ? '0 : ptr_q + 1'b1;

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         ptr_q <= '0;
      end
      else if (alloc)
      begin
         ptr_q <= ptr_next;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         vl_q <= vpu_pkg::vlen_t'(vpu_pkg::VL_RESET);
      end
      else if (accept && is_setvl)
      begin
         vl_q <= clamp_vl(instr_i.imm);
      end
   end

   assign idle_o = all_idle;

endmodule

//--- port_group/port_group_unit.sv
`timescale 1ns/100ps

module port_group_unit (
   input  logic               clk,
   input  logic               rstn,

   input  logic               start_i,
   input  vpu_pkg::port_cmd_t cmd_i,
   output logic               idle_o,

   output vpu_pkg::wb_req_t   wb_req_o,
   input  vpu_pkg::wb_rsp_t   wb_rsp_i
);

   vpu_pkg::pg_state_t state_q;
   vpu_pkg::port_cmd_t cmd_q;
   vpu_pkg::vlen_t     elem_q;
   vpu_pkg::elem_t     op_a_q;
   vpu_pkg::elem_t     op_b_q;
   vpu_pkg::elem_t     result;
   vpu_pkg::vaddr_t    offset;
   logic               act_q;
   logic               done;
   logic               last_elem;

   assign offset    = {3'b000, elem_q};
   assign done      = act_q && wb_rsp_i.ack;
   assign last_elem = (elem_q == cmd_q.vl - 1'b1);

   always_comb
   begin
      case (cmd_q.opcode)
         vpu_pkg::OP_ADD: result = op_a_q + op_b_q;
         vpu_pkg::OP_SUB: result = op_a_q - op_b_q;
         vpu_pkg::OP_AND: result = op_a_q & op_b_q;
         vpu_pkg::OP_XOR: result = op_a_q ^ op_b_q;
         default:         result = '0;
      endcase
   end

   // One transfer per state; cyc drops for a cycle after each ack
   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         state_q <= vpu_pkg::PG_IDLE;
         act_q   <= 1'b0;
         elem_q  <= '0;
      end
      else
      begin
         case (state_q)
            vpu_pkg::PG_IDLE:
            begin
               if (start_i)
               begin
                  state_q <= vpu_pkg::PG_RD1;
                  elem_q  <= '0;
               end
            end
            vpu_pkg::PG_RD1:
            begin
               act_q <= 1'b1;
               if (done)
               begin
                  act_q   <= 1'b0;
                  state_q <= vpu_pkg::PG_RD2;
               end
            end
            vpu_pkg::PG_RD2:
            begin
               act_q <= 1'b1;
               if (done)
               begin
                  act_q   <= 1'b0;
                  state_q <= vpu_pkg::PG_WR;
               end
            end
            default:
            begin
               act_q <= 1'b1;
               if (done)
               begin
                  act_q <= 1'b0;
                  if (last_elem)
                  begin
                     state_q <= vpu_pkg::PG_IDLE;
                  end
                  else
                  begin
                     elem_q  <= elem_q + 1'b1;
                     state_q <= vpu_pkg::PG_RD1;
                  end
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (state_q == vpu_pkg::PG_IDLE && start_i)
      begin
         cmd_q <= cmd_i;
      end
      if (state_q == vpu_pkg::PG_RD1 && done)
      begin
         op_a_q <= wb_rsp_i.dat;
      end
      if (state_q == vpu_pkg::PG_RD2 && done)
      begin
         op_b_q <= wb_rsp_i.dat;
      end
   end

   always_comb
   begin
      wb_req_o.cyc = act_q;
      wb_req_o.stb = act_q;
      wb_req_o.we  = (state_q == vpu_pkg::PG_WR);
      wb_req_o.dat = result;
      case (state_q)
         vpu_pkg::PG_RD1: wb_req_o.adr = cmd_q.vs1 + offset;
         vpu_pkg::PG_RD2: wb_req_o.adr = cmd_q.vs2 + offset;
         default:         wb_req_o.adr = cmd_q.vd + offset;
      endcase
   end

   assign idle_o = (state_q == vpu_pkg::PG_IDLE);

endmodule

//--- verilog/vrf_arbiter.sv
`timescale 1ns/100ps

module vrf_arbiter #(
   parameter int W_PORTS_NUM = vpu_pkg::NUM_PORT_GROUPS
) (
   input  logic                               clk,
   input  logic                               rstn,

   input  vpu_pkg::wb_req_t [W_PORTS_NUM:0]   m_req_i,
   output vpu_pkg::wb_rsp_t [W_PORTS_NUM:0]   m_rsp_o,

   output vpu_pkg::wb_req_t                   s_req_o,
   input  vpu_pkg::wb_rsp_t                   s_rsp_i
);

   // Master 0 is the host, the port groups follow it
   localparam int NUM_M = W_PORTS_NUM + 1;
   localparam int GNT_W = $clog2(NUM_M);

   logic [GNT_W-1:0] grant_q;
   logic [GNT_W-1:0] next_grant;
   logic [GNT_W-1:0] gnt;
   logic [NUM_M-1:0] req_cyc;
   logic             lock_q;
   logic             hold;

   always_comb
   begin
      for (int i = 0; i < NUM_M; i++)
      begin
         req_cyc[i] = m_req_i[i].cyc;
      end
   end

   // Search starts after the last grant and ends on it
   always_comb
   begin
      int  idx;
      logic found;
      next_grant = grant_q;
      found      = 1'b0;
      for (int k = 1; k <= NUM_M; k++)
      begin
         idx = (int'(grant_q) + k) % NUM_M;
         if (!found && req_cyc[idx])
         begin
            next_grant = GNT_W'(idx);
            found      = 1'b1;
         end
      end
   end

   assign hold = lock_q && req_cyc[grant_q];
   assign gnt  = hold ? grant_q : next_grant;

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         grant_q <= '0;
         lock_q  <= 1'b0;
      end
      else if (!hold)
      begin
         lock_q <= |req_cyc;
         if (|req_cyc)
         begin
            grant_q <= next_grant;
         end
      end
   end

   always_comb
   begin
      s_req_o = '0;
      if (req_cyc[gnt])
      begin
         s_req_o = m_req_i[gnt];
      end
   end

   always_comb
   begin
      for (int i = 0; i < NUM_M; i++)
      begin
         m_rsp_o[i] = '0;
         if (gnt == GNT_W'(i))
         begin
            m_rsp_o[i] = s_rsp_i;
         end
      end
   end

endmodule

//--- verilog/vrf_memory.sv
`timescale 1ns/100ps

module vrf_memory (
   input  logic             clk,
   input  logic             rstn,

   input  vpu_pkg::wb_req_t wb_req_i,
   output vpu_pkg::wb_rsp_t wb_rsp_o
);

   vpu_pkg::elem_t mem_q [vpu_pkg::VRF_DEPTH];
   vpu_pkg::elem_t rd_q;
   logic           ack_q;
   logic           req;

   assign req = wb_req_i.cyc && wb_req_i.stb;

   // ack lasts one cycle even though the master still holds stb during it
   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         ack_q <= 1'b0;
      end
      else
      begin
         ack_q <= req && !ack_q;
      end
   end

   always_ff @(posedge clk)
   begin
      if (req && !ack_q)
      begin
         rd_q <= mem_q[wb_req_i.adr];
      end
      if (req && ack_q && wb_req_i.we)
      begin
         mem_q[wb_req_i.adr] <= wb_req_i.dat;
      end
   end

   always_comb
   begin
      wb_rsp_o.ack = ack_q;
      wb_rsp_o.dat = rd_q;
   end

endmodule

//--- verilog/vector_issue_top.sv
`timescale 1ns/100ps

module vector_issue_top #(
   parameter int W_PORTS_NUM = vpu_pkg::NUM_PORT_GROUPS
) (
   input  logic                clk,
   input  logic                rstn,

   input  logic                instr_vld_i,
   input  vpu_pkg::vec_instr_t instr_i,
   output logic                instr_rdy_o,
   output logic                idle_o,

   input  vpu_pkg::wb_req_t    host_wb_req_i,
   output vpu_pkg::wb_rsp_t    host_wb_rsp_o
);

   logic [W_PORTS_NUM-1:0]           pg_idle;
   logic [W_PORTS_NUM-1:0]           pg_start;
   vpu_pkg::port_cmd_t               pg_cmd;
   vpu_pkg::wb_req_t [W_PORTS_NUM:0] m_req;
   vpu_pkg::wb_rsp_t [W_PORTS_NUM:0] m_rsp;
   vpu_pkg::wb_req_t                 vrf_req;
   vpu_pkg::wb_rsp_t                 vrf_rsp;

   assign m_req[0]      = host_wb_req_i;
   assign host_wb_rsp_o = m_rsp[0];

   port_allocate_unit #(
      .W_PORTS_NUM (W_PORTS_NUM)
   ) port_allocate_unit_i (
      .clk         (clk),
      .rstn        (rstn),
      .instr_vld_i (instr_vld_i),
      .instr_i     (instr_i),
      .instr_rdy_o (instr_rdy_o),
      .port_rdy_i  (pg_idle),
      .start_o     (pg_start),
      .cmd_o       (pg_cmd),
      .idle_o      (idle_o)
   );

   generate
      for (genvar g = 0; g < W_PORTS_NUM; g++)
      begin : gen_port_group
         port_group_unit port_group_unit_i (
            .clk      (clk),
            .rstn     (rstn),
            .start_i  (pg_start[g]),
            .cmd_i    (pg_cmd),
            .idle_o   (pg_idle[g]),
            .wb_req_o (m_req[g+1]),
            .wb_rsp_i (m_rsp[g+1])
         );
      end
   endgenerate

   vrf_arbiter #(
      .W_PORTS_NUM (W_PORTS_NUM)
   ) vrf_arbiter_i (
      .clk     (clk),
      .rstn    (rstn),
      .m_req_i (m_req),
      .m_rsp_o (m_rsp),
      .s_req_o (vrf_req),
      .s_rsp_i (vrf_rsp)
   );

   vrf_memory vrf_memory_i (
      .clk      (clk),
      .rstn     (rstn),
      .wb_req_i (vrf_req),
      .wb_rsp_o (vrf_rsp)
   );

endmodule

//--- tests/tb_vector_issue.sv
`timescale 1ns/100ps

module tb_vector_issue;

   localparam int TIMEOUT = 2000;

   logic                clk;
   logic                rstn;
   logic                instr_vld_i;
   vpu_pkg::vec_instr_t instr_i;
   logic                instr_rdy_o;
   logic                idle_o;
   vpu_pkg::wb_req_t    host_wb_req_i;
   vpu_pkg::wb_rsp_t    host_wb_rsp_o;

   logic [31:0] lfsr_q;
   int          errors;
   int          cases;
   int          failed_cases;

   vector_issue_top vector_issue_top_i (
      .clk           (clk),
      .rstn          (rstn),
      .instr_vld_i   (instr_vld_i),
      .instr_i       (instr_i),
      .instr_rdy_o   (instr_rdy_o),
      .idle_o        (idle_o),
      .host_wb_req_i (host_wb_req_i),
      .host_wb_rsp_o (host_wb_rsp_o)
   );

   always #10 clk = ~clk;

   // Taps for x^32 + x^22 + x^2 + x + 1, the new bit enters at the bottom
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic rand_elem(output vpu_pkg::elem_t val);
      val = '0;
      for (int i = 0; i < 16; i++)
      begin
         lfsr_q = lfsr_step(lfsr_q);
         val    = {val[14:0], lfsr_q[0]};
      end
   endtask

   // Element rules: 0 add, 1 sub, 2 and, 3 xor, all modulo 2^16
   function automatic vpu_pkg::elem_t expected_result(input int op, input vpu_pkg::elem_t a,
                                                      input vpu_pkg::elem_t b);
      vpu_pkg::elem_t res;
      case (op)
         0: res = a + b;
         1: res = a - b;
         2: res = a & b;
         default: res = a ^ b;
      endcase
      return res;
   endfunction

   task automatic host_xfer(input logic we, input vpu_pkg::vaddr_t adr,
                            input vpu_pkg::elem_t wdat, output vpu_pkg::elem_t rdat);
      int n;
      n = 0;
      @(posedge clk);
      host_wb_req_i.cyc <= 1'b1;
      host_wb_req_i.stb <= 1'b1;
      host_wb_req_i.we  <= we;
      host_wb_req_i.adr <= adr;
      host_wb_req_i.dat <= wdat;
      do
      begin
         @(negedge clk);
         n++;
      end while (!host_wb_rsp_o.ack && n < TIMEOUT);
      rdat = host_wb_rsp_o.dat;
      if (!host_wb_rsp_o.ack)
      begin
         $display("Host transfer to address %h got no acknowledge in %0d cycles", adr, TIMEOUT);
         errors++;
      end
      @(posedge clk);
      host_wb_req_i <= '0;
   endtask

   task automatic issue_instr(input vpu_pkg::vec_instr_t ins, output int held);
      int n;
      held = 0;
      n    = 0;
      @(posedge clk);
      instr_vld_i <= 1'b1;
      instr_i     <= ins;
      @(negedge clk);
      while (!instr_rdy_o && n < TIMEOUT)
      begin
         held++;
         n++;
         @(negedge clk);
      end
      if (!instr_rdy_o)
      begin
         $display("Instruction was not accepted within %0d cycles", TIMEOUT);
         errors++;
      end
      else if (ins.opcode == vpu_pkg::OP_SETVL)
      begin
         assert (idle_o === 1'b1)
         else
         begin
            $display("Vector length update was accepted while a port group was busy");
            errors++;
         end
      end
      @(posedge clk);
      instr_vld_i <= 1'b0;
   endtask

   task automatic wait_idle();
      int n;
      n = 0;
      @(negedge clk);
      while (!idle_o && n < TIMEOUT)
      begin
         n++;
         @(negedge clk);
      end
      if (!idle_o)
      begin
         $display("idle_o did not rise within %0d cycles", TIMEOUT);
         errors++;
      end
   endtask

   task automatic check_word(input vpu_pkg::vaddr_t adr, input vpu_pkg::elem_t exp,
                             inout bit ok);
      vpu_pkg::elem_t got;
      host_xfer(1'b0, adr, '0, got);
      assert (got === exp)
      else
      begin
         $display("** Error: host_wb_rsp_o.dat at %h: expected %h, got %h", adr, exp, got);
         errors++;
         ok = 1'b0;
      end
   endtask

   task automatic report_case(input string what, input bit ok);
      cases++;
      if (!ok)
      begin
         failed_cases++;
      end
      $display("case %0d %s: %s", cases, what, ok ? "pass" : "FAIL");
   endtask

   // Five arithmetic instructions on random data, one more than there are groups
   task automatic run_burst(input vpu_pkg::vaddr_t base, input int vl);
      vpu_pkg::elem_t      src_a [16];
      vpu_pkg::elem_t      src_b [16];
      vpu_pkg::elem_t      dummy;
      vpu_pkg::vec_instr_t ins;
      int                  held;
      bit                  ok;
      ok = 1'b1;
      for (int i = 0; i < 16; i++)
      begin
         rand_elem(src_a[i]);
         rand_elem(src_b[i]);
         host_xfer(1'b1, vpu_pkg::vaddr_t'(base + i), src_a[i], dummy);
         host_xfer(1'b1, vpu_pkg::vaddr_t'(base + 16 + i), src_b[i], dummy);
      end
      ins        = '0;
      ins.opcode = vpu_pkg::OP_SETVL;
      ins.imm    = vpu_pkg::vlen_t'(vl);
      issue_instr(ins, held);
      for (int k = 0; k < 5; k++)
      begin
         ins.opcode = vpu_pkg::opcode_t'(k % 4);
         ins.vd     = vpu_pkg::vaddr_t'(base + 32 + 16 * k);
         ins.vs1    = base;
         ins.vs2    = vpu_pkg::vaddr_t'(base + 16);
         ins.imm    = '0;
         issue_instr(ins, held);
         if (k == 4)
         begin
            assert (held > 0)
            else
            begin
               $display("Fifth instruction was accepted while every port group was busy");
               errors++;
               ok = 1'b0;
            end
         end
      end
      ins        = '0;
      ins.opcode = vpu_pkg::OP_SETVL;
      ins.imm    = vpu_pkg::vlen_t'(vl);
      issue_instr(ins, held);
      assert (held > 0)
      else
      begin
         $display("Vector length update did not wait for the busy port groups");
         errors++;
         ok = 1'b0;
      end
      wait_idle();
      for (int k = 0; k < 5; k++)
      begin
         for (int i = 0; i < vl; i++)
         begin
            check_word(vpu_pkg::vaddr_t'(base + 32 + 16 * k + i),
                       expected_result(k % 4, src_a[i], src_b[i]), ok);
         end
      end
      report_case($sformatf("burst at %h with length %0d", base, vl), ok);
   endtask

   initial
   begin
      int                  fd;
      int                  code;
      int                  held;
      bit                  ok;
      logic [63:0]         cmd;
      logic [8*256-1:0]    rest;
      logic [31:0]         adr;
      logic [31:0]         cnt;
      logic [31:0]         val;
      logic [31:0]         vd;
      logic [31:0]         vs1;
      logic [31:0]         vs2;
      vpu_pkg::elem_t      dummy;
      vpu_pkg::vec_instr_t ins;

      clk           = 1'b0;
      rstn          = 1'b0;
      instr_vld_i   = 1'b0;
      instr_i       = '0;
      host_wb_req_i = '0;
      lfsr_q        = 32'h62f;
      errors        = 0;
      cases         = 0;
      failed_cases  = 0;

      repeat (10) @(posedge clk);
      rstn <= 1'b1;
      @(negedge clk);
      ok = 1'b1;
      assert (idle_o === 1'b1)
      else
      begin
         $display("** Error: idle_o after reset: expected 1, got %h", idle_o);
         errors++;
         ok = 1'b0;
      end
      assert (instr_rdy_o === 1'b1)
      else
      begin
         $display("** Error: instr_rdy_o after reset: expected 1, got %h", instr_rdy_o);
         errors++;
         ok = 1'b0;
      end
      report_case("reset state", ok);

      fd = $fopen("tests/vector_cases.txt", "r");
      if (fd == 0)
      begin
         $display("Could not open tests/vector_cases.txt");
         errors++;
      end
      else
      begin
         while ($fscanf(fd, "%s", cmd) == 1)
         begin
            case (cmd)
               "#": code = $fgets(rest, fd);
               "W":
               begin
                  code = $fscanf(fd, "%h %h", adr, cnt);
                  for (int i = 0; i < cnt; i++)
                  begin
                     code = $fscanf(fd, "%h", val);
                     host_xfer(1'b1, vpu_pkg::vaddr_t'(adr + i), val[15:0], dummy);
                  end
               end
               "I":
               begin
                  code       = $fscanf(fd, "%h %h %h %h", val, vd, vs1, vs2);
                  ins        = '0;
                  ins.opcode = vpu_pkg::opcode_t'(val[2:0]);
                  ins.vd     = vd[7:0];
                  ins.vs1    = vs1[7:0];
                  ins.vs2    = vs2[7:0];
                  issue_instr(ins, held);
               end
               "S":
               begin
                  code       = $fscanf(fd, "%h", val);
                  ins        = '0;
                  ins.opcode = vpu_pkg::OP_SETVL;
                  ins.imm    = val[4:0];
                  issue_instr(ins, held);
               end
               "Q": wait_idle();
               "R":
               begin
                  code = $fscanf(fd, "%h %h", adr, cnt);
                  ok   = 1'b1;
                  for (int i = 0; i < cnt; i++)
                  begin
                     code = $fscanf(fd, "%h", val);
                     check_word(vpu_pkg::vaddr_t'(adr + i), val[15:0], ok);
                  end
                  report_case($sformatf("read of %0d words at %h", cnt, adr[7:0]), ok);
               end
               "B":
               begin
                  code = $fscanf(fd, "%h %h", adr, val);
                  run_burst(adr[7:0], val);
               end
               default:
               begin
                  $display("Unknown command %0s in the case file", cmd);
                  errors++;
                  code = $fgets(rest, fd);
               end
            endcase
         end
         $fclose(fd);
      end

      $display("%0d cases, %0d failed, %0d errors", cases, failed_cases, errors);
      if (errors == 0 && failed_cases == 0)
      begin
         $display("Done: no errors");
      end
      else
      begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

//--- tests/vector_cases.txt
# Columns: W adr n d0.. | R adr n e0.. | I op vd vs1 vs2 | S imm | Q | B base vl
# All numbers are hex, op 0 add, 1 sub, 2 and, 3 xor
W 00 4 0001 8000 fff0 1234
W 10 4 0002 8001 0020 4321
W 24 1 dead
I 0 20 00 10
Q
R 20 5 0003 0001 0010 5555 dead
I 1 30 00 10
Q
R 30 4 ffff ffff ffd0 cf13
I 2 40 00 10
Q
R 40 4 0000 8000 0020 0220
I 3 50 00 10
Q
R 50 4 0003 0001 ffd0 5115
W 60 10 0001 0002 0003 0004 0005 0006 0007 0008 0009 000a 000b 000c 000d 000e 000f 0010
W 70 10 0100 0200 0300 0400 0500 0600 0700 0800 0900 0a00 0b00 0c00 0d00 0e00 0f00 1000
W 90 a beef beef beef beef beef beef beef beef beef beef
S 9
I 0 90 60 70
Q
R 90 a 0101 0202 0303 0404 0505 0606 0707 0808 0909 beef
W a0 2 beef beef
S 0
I 3 a0 60 70
Q
R a0 2 0101 beef
W b0 11 beef beef beef beef beef beef beef beef beef beef beef beef beef beef beef beef beef
S 14
I 0 b0 60 70
Q
R b0 11 0101 0202 0303 0404 0505 0606 0707 0808 0909 0a0a 0b0b 0c0c 0d0d 0e0e 0f0f 1010 beef
S 4
I 0 c0 00 10
I 1 c4 00 10
I 2 c8 00 10
I 3 cc 00 10
R 00 4 0001 8000 fff0 1234
R 10 4 0002 8001 0020 4321
Q
R c0 10 0003 0001 0010 5555 ffff ffff ffd0 cf13 0000 8000 0020 0220 0003 0001 ffd0 5115
B 00 10

//--- tb.f
common/vpu_pkg.sv
verilog/port_allocate_unit.sv
port_group/port_group_unit.sv
verilog/vrf_arbiter.sv
verilog/vrf_memory.sv
verilog/vector_issue_top.sv
tests/tb_vector_issue.sv

//--- Bender.yml
package:
  name: vector_issue

sources:
  - common/vpu_pkg.sv
  - verilog/port_allocate_unit.sv
  - port_group/port_group_unit.sv
  - verilog/vrf_arbiter.sv
  - verilog/vrf_memory.sv
  - verilog/vector_issue_top.sv
  - target: test
    files:
      - tests/tb_vector_issue.sv
